// ==== common/scurvePkg.sv ====
package scurvePkg;

  //////////////////////////////////////////////////
  // Run settings and slow-control image
  //////////////////////////////////////////////////

  typedef struct packed {
    logic       singleChn;    // 1: one channel, 0: all 64
    logic [5:0] testChn;
    logic       ctestInject;  // 1: test pin, 0: input pin
    logic [9:0] startDac;
    logic [9:0] endDac;
    logic [9:0] dacStep;
    logic [2:0] asicNumber;   // Chained ASICs to load
    logic       unmaskAll;
  } scanParamT;

  typedef struct packed {
    logic [63:0]  ctestChn;    // One-hot test pin select
    logic [9:0]   dacCode;     // LSB first on the ASIC side
    logic [191:0] discriMask;  // Three per channel, 1 enables
    logic         forceExtRaz;
  } scConfigT;

  localparam int SC_BITS = $bits(scConfigT);

  localparam scConfigT SC_CONFIG_IDLE = '{
    ctestChn:    '0,
    dacCode:     '0,
    discriMask:  '1,
    forceExtRaz: 1'b0
  };

  // Stream words
  localparam logic [15:0] SCURVE_HEADER     = 16'h5343;  // "SC"
  localparam logic [15:0] SCURVE_TAIL       = 16'hFF45;
  localparam logic [7:0]  CHN_TAG_SINGLE    = 8'h43;     // "C"
  localparam logic [7:0]  CHN_TAG_ALL       = 8'h63;     // "c"
  localparam logic [15:0] CHN_WORD_UNMASKED = 16'h43FF;
  localparam logic [3:0]  DAC_TAG           = 4'hD;

  // Settle delay shortened from 40000 cycles
  localparam int SC_SETTLE_CYCLES = 64;
  localparam int TRIG_WINDOW      = 32;
  localparam int TRIG_FIFO_DEPTH  = 4;
  localparam int USB_FIFO_DEPTH   = 16;

  // Counter widths and terminal counts
  localparam int SC_CNT_W     = $clog2(SC_BITS);
  localparam int SETTLE_CNT_W = $clog2(SC_SETTLE_CYCLES);
  localparam int WINDOW_CNT_W = $clog2(TRIG_WINDOW);
  localparam logic [SC_CNT_W-1:0]     SC_LAST_BIT = SC_CNT_W'(SC_BITS - 1);
  localparam logic [SETTLE_CNT_W-1:0] SETTLE_LAST = SETTLE_CNT_W'(SC_SETTLE_CYCLES - 1);
  localparam logic [WINDOW_CNT_W-1:0] WINDOW_LAST = WINDOW_CNT_W'(TRIG_WINDOW - 1);

endpackage

// ==== rtl/syncFifo.sv ====
module syncFifo #(
  parameter int DEPTH = 4  // Power of two
) (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        wrEn,
  input  logic [15:0] wrData,
  input  logic        rdEn,
  output logic [15:0] rdData,
  output logic        full,
  output logic        empty
);

  logic [15:0]              mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wrPtr;
  logic [$clog2(DEPTH)-1:0] rdPtr;
  logic [$clog2(DEPTH):0]   count;  // Occupancy, 0 to DEPTH
  logic                     doWrite;
  logic                     doRead;

  assign doWrite = wrEn && !full;  // Drop when full
  assign doRead  = rdEn && !empty;

  always_ff @(posedge Clk) begin
    if (doWrite) mem[wrPtr] <= wrData;
  end

  // Pointers wrap on their own
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) wrPtr <= wrPtr + 1'b1;
      if (doRead) rdPtr <= rdPtr + 1'b1;
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign rdData = mem[rdPtr];  // First word falls through
  assign full   = count[$clog2(DEPTH)];
  assign empty  = (count == '0);

  noWriteWhenFull: assert property (@(posedge Clk) disable iff (!reset_n)
    wrEn |-> !full);

  noReadWhenEmpty: assert property (@(posedge Clk) disable iff (!reset_n)
    rdEn |-> !empty);

endmodule

// ==== rtl/triggerCounter.sv ====
module triggerCounter (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        windowStart,
  input  logic        trigger,
  output logic [15:0] fifoWord,
  output logic        fifoWr,
  output logic        windowDone
);

  logic                                counting;
  logic [scurvePkg::WINDOW_CNT_W-1:0]  winCnt;
  logic [15:0]                         trigCount;
  logic [15:0]                         nextCount;
  logic                                lastSample;

  assign nextCount  = trigCount + {15'd0, trigger};
  assign lastSample = counting && (winCnt == scurvePkg::WINDOW_LAST);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      counting   <= 1'b0;
      winCnt     <= '0;
      trigCount  <= '0;
      fifoWr     <= 1'b0;
      windowDone <= 1'b0;
    end else begin
      fifoWr     <= lastSample;
      windowDone <= fifoWr;  // One cycle behind the FIFO write
      if (windowStart && !counting) begin
        counting  <= 1'b1;
        winCnt    <= '0;
        trigCount <= '0;
      end else if (counting) begin
        trigCount <= nextCount;
        winCnt    <= winCnt + 1'b1;
        if (lastSample) counting <= 1'b0;
      end
    end
  end

  // Count word includes the final sample
  always_ff @(posedge Clk) begin
    if (lastSample) fifoWord <= nextCount;
  end

endmodule

// ==== rtl/scParamLoader.sv ====
module scParamLoader (
  input  logic                Clk,
  input  logic                reset_n,
  input  logic                scLoad,
  input  scurvePkg::scConfigT scConfig,
  output logic                srData,
  output logic                srEn,
  output logic                configDone
);

  logic [scurvePkg::SC_BITS-1:0]  shiftReg;
  logic [scurvePkg::SC_CNT_W-1:0] bitCnt;
  logic                           busy;

  // Snapshot, then MSB first
  always_ff @(posedge Clk) begin
    if (scLoad && !busy) begin
      shiftReg <= scConfig;
    end else if (busy) begin
      shiftReg <= shiftReg << 1;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      busy       <= 1'b0;
      bitCnt     <= '0;
      configDone <= 1'b0;
    end else begin
      configDone <= 1'b0;
      if (scLoad && !busy) begin
        busy   <= 1'b1;
        bitCnt <= '0;
      end else if (busy) begin
        bitCnt <= bitCnt + 1'b1;
        if (bitCnt == scurvePkg::SC_LAST_BIT) begin  // Last bit on the line now
          busy       <= 1'b0;
          configDone <= 1'b1;
        end
      end
    end
  end

  assign srEn   = busy;
  assign srData = busy & shiftReg[scurvePkg::SC_BITS-1];

  noReloadWhileBusy: assert property (@(posedge Clk) disable iff (!reset_n)
    scLoad |-> !busy);

endmodule

// ==== scanControl/scurveScanControl.sv ====
module scurveScanControl (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 testStart,
  input  scurvePkg::scanParamT scanParam,
  input  logic                 configDone,
  input  logic                 windowDone,
  input  logic [15:0]          trigData,
  input  logic                 trigEmpty,
  input  logic                 usbFull,
  input  logic                 transmitDone,
  output scurvePkg::scConfigT  scConfig,
  output logic                 scLoad,
  output logic                 windowStart,
  output logic                 trigRdEn,
  output logic [15:0]          usbWord,
  output logic                 usbWrEn,
  output logic                 testDone
);

  typedef enum logic [4:0] {
    IDLE, HEADER, CHANNEL, DAC, LOAD, LOAD_WAIT, SETTLE, WINDOW, WINDOW_WAIT,
    DRAIN, DRAIN_RD, DRAIN_WR, NEXT_POINT, NEXT_CHN, TAIL, TAIL_WAIT, DONE
  } stateT;

  stateT                  state;
  scurvePkg::scanParamT   runParam;  // Captured at start
  logic [5:0]             chn;
  logic [9:0]             dacCode;
  logic [2:0]             asicCnt;
  logic [scurvePkg::SETTLE_CNT_W-1:0] settleCnt;
  logic [3:0]             tailCnt;
  logic [15:0]            pendWord;  // Count word waiting for USB room
  logic                   canWrite;
  logic [15:0]            chnWord;
  logic [63:0]            ctestVec;
  logic [191:0]           maskVec;

  // ASIC takes the DAC code LSB first
  function automatic logic [9:0] bitReverse(input logic [9:0] code);
    logic [9:0] rev;
    for (int i = 0; i < 10; i++) begin
      rev[i] = code[9-i];
    end
    return rev;
  endfunction

  // No write right after a write, so usbFull is always current
  assign canWrite = !usbFull && !usbWrEn;

  always_comb begin
    ctestVec = runParam.ctestInject ? (64'd1 << chn) : 64'd0;
    maskVec  = runParam.unmaskAll ? {192{1'b1}} : (192'd7 << (8'd3 * chn));
    if (runParam.unmaskAll) begin
      chnWord = scurvePkg::CHN_WORD_UNMASKED;
    end else if (runParam.singleChn) begin
      chnWord = {scurvePkg::CHN_TAG_SINGLE, 2'b00, chn};
    end else begin
      chnWord = {scurvePkg::CHN_TAG_ALL, 2'b00, chn};
    end
  end

  //////////////////////////////////////////////////
  // Scan FSM
  //////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= IDLE;
      runParam    <= '0;
      chn         <= '0;
      dacCode     <= '0;
      asicCnt     <= '0;
      settleCnt   <= '0;
      tailCnt     <= '0;
      pendWord    <= '0;
      usbWord     <= '0;
      scConfig    <= scurvePkg::SC_CONFIG_IDLE;
      scLoad      <= 1'b0;
      windowStart <= 1'b0;
      trigRdEn    <= 1'b0;
      usbWrEn     <= 1'b0;
      testDone    <= 1'b0;
    end else begin
      scLoad      <= 1'b0;  // Strobes default low
      windowStart <= 1'b0;
      trigRdEn    <= 1'b0;
      usbWrEn     <= 1'b0;
      case (state)
        IDLE: begin
          if (!testStart) begin  // Abort clears the run
            chn       <= '0;
            dacCode   <= '0;
            asicCnt   <= '0;
            settleCnt <= '0;
            tailCnt   <= '0;
            scConfig  <= scurvePkg::SC_CONFIG_IDLE;
            testDone  <= 1'b0;
          end else begin
            runParam <= scanParam;
            chn      <= scanParam.singleChn ? scanParam.testChn : 6'd0;
            state    <= HEADER;
          end
        end
        HEADER: if (canWrite) begin
          usbWord <= scurvePkg::SCURVE_HEADER;
          usbWrEn <= 1'b1;
          state   <= CHANNEL;
        end
        CHANNEL: if (canWrite) begin
          usbWord             <= chnWord;
          usbWrEn             <= 1'b1;
          scConfig.ctestChn   <= ctestVec;
          scConfig.discriMask <= maskVec;
          dacCode             <= runParam.startDac;
          state               <= DAC;
        end
        DAC: if (canWrite) begin
          usbWord          <= {scurvePkg::DAC_TAG, 2'b00, dacCode};
          usbWrEn          <= 1'b1;
          scConfig.dacCode <= bitReverse(dacCode);
          asicCnt          <= '0;
          state            <= LOAD;
        end
        LOAD: begin
          if (asicCnt == runParam.asicNumber) begin
            state <= WINDOW;
          end else begin
            scLoad               <= 1'b1;
            scConfig.forceExtRaz <= 1'b1;
            asicCnt              <= asicCnt + 1'b1;
            state                <= LOAD_WAIT;
          end
        end
        LOAD_WAIT: if (configDone) begin
          settleCnt <= '0;
          state     <= SETTLE;
        end
        SETTLE: begin
          if (settleCnt == scurvePkg::SETTLE_LAST) begin
            scConfig.forceExtRaz <= 1'b0;
            state                <= LOAD;
          end else begin
            settleCnt <= settleCnt + 1'b1;
          end
        end
        WINDOW: begin
          windowStart <= 1'b1;
          state       <= WINDOW_WAIT;
        end
        WINDOW_WAIT: if (windowDone) state <= DRAIN;
        DRAIN: begin
          if (trigEmpty) begin
            state <= NEXT_POINT;
          end else begin
            trigRdEn <= 1'b1;
            state    <= DRAIN_RD;
          end
        end
        DRAIN_RD: begin
          pendWord <= trigData;
          state    <= DRAIN_WR;
        end
        DRAIN_WR: if (canWrite) begin
          usbWord <= pendWord;
          usbWrEn <= 1'b1;
          state   <= DRAIN;
        end
        NEXT_POINT: begin
          if (dacCode == runParam.endDac) begin
            state <= NEXT_CHN;
          end else begin
            dacCode <= dacCode + runParam.dacStep;
            state   <= DAC;
          end
        end
        NEXT_CHN: begin
          if (runParam.singleChn || chn == 6'd63) begin
            state <= TAIL;
          end else begin
            chn   <= chn + 1'b1;
            state <= CHANNEL;
          end
        end
        TAIL: if (canWrite) begin
          usbWord <= scurvePkg::SCURVE_TAIL;
          usbWrEn <= 1'b1;
          tailCnt <= '0;
          state   <= TAIL_WAIT;
        end
        TAIL_WAIT: begin  // Give the host time to pull the tail
          if (tailCnt == 4'd15) begin
            testDone <= 1'b1;
            state    <= DONE;
          end else begin
            tailCnt <= tailCnt + 1'b1;
          end
        end
        DONE: if (transmitDone) begin
          testDone <= 1'b0;
          state    <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  usbNoOverflow: assert property (@(posedge Clk) disable iff (!reset_n)
    usbWrEn |-> !usbFull);

  scLoadPulse: assert property (@(posedge Clk) disable iff (!reset_n)
    scLoad |=> !scLoad);

endmodule

// ==== rtl/scurveTestTop.sv ====
module scurveTestTop (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 testStart,
  input  scurvePkg::scanParamT scanParam,
  input  logic                 trigger,
  input  logic                 usbRd,
  input  logic                 transmitDone,
  output scurvePkg::scConfigT  scConfig,
  output logic                 srData,
  output logic                 srEn,
  output logic [15:0]          usbData,
  output logic                 usbEmpty,
  output logic                 testDone
);

  logic        windowStart;
  logic        windowDone;
  logic [15:0] cntWord;
  logic        cntWr;
  logic [15:0] trigData;
  logic        trigEmpty;
  logic        trigRdEn;
  logic        scLoad;
  logic        configDone;
  logic [15:0] usbWord;
  logic        usbWrEn;
  logic        usbFull;

  //////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////

  triggerCounter triggerCounter_i (
    .Clk        (Clk),
    .reset_n    (reset_n),
    .windowStart(windowStart),
    .trigger    (trigger),
    .fifoWord   (cntWord),
    .fifoWr     (cntWr),
    .windowDone (windowDone)
  );

  syncFifo #(.DEPTH(scurvePkg::TRIG_FIFO_DEPTH)) trigFifo_i (
    .Clk    (Clk),
    .reset_n(reset_n),
    .wrEn   (cntWr),
    .wrData (cntWord),
    .rdEn   (trigRdEn),
    .rdData (trigData),
    .full   (),         // Drained before every window
    .empty  (trigEmpty)
  );

  //////////////////////////////////////////////////
  // Scan control and slow control
  //////////////////////////////////////////////////

  scurveScanControl scurveScanControl_i (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .testStart   (testStart),
    .scanParam   (scanParam),
    .configDone  (configDone),
    .windowDone  (windowDone),
    .trigData    (trigData),
    .trigEmpty   (trigEmpty),
    .usbFull     (usbFull),
    .transmitDone(transmitDone),
    .scConfig    (scConfig),
    .scLoad      (scLoad),
    .windowStart (windowStart),
    .trigRdEn    (trigRdEn),
    .usbWord     (usbWord),
    .usbWrEn     (usbWrEn),
    .testDone    (testDone)
  );

  scParamLoader scParamLoader_i (
    .Clk       (Clk),
    .reset_n   (reset_n),
    .scLoad    (scLoad),
    .scConfig  (scConfig),
    .srData    (srData),
    .srEn      (srEn),
    .configDone(configDone)
  );

  // Output side where the host pulls words
  syncFifo #(.DEPTH(scurvePkg::USB_FIFO_DEPTH)) usbFifo_i (
    .Clk    (Clk),
    .reset_n(reset_n),
    .wrEn   (usbWrEn),
    .wrData (usbWord),
    .rdEn   (usbRd),
    .rdData (usbData),
    .full   (usbFull),
    .empty  (usbEmpty)
  );

endmodule

// ==== verification/scurveTestTb.sv ====
module scurveTestTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_ROWS     = 4;
  localparam int          STALL_CYCLES = 1500;  // Host silent this long in stalled rows
  localparam int unsigned LCG_SEED     = 89526;

  typedef struct packed {
    scurvePkg::scanParamT param;
    logic [10:0]          threshold;  // Trigger high below this DAC code
    logic                 stall;
  } rowT;

  logic                 Clk;
  logic                 reset_n;
  logic                 testStart;
  scurvePkg::scanParamT scanParam;
  logic                 trigger;
  logic                 usbRd;
  logic                 transmitDone;
  scurvePkg::scConfigT  scConfig;
  logic                 srData;
  logic                 srEn;
  logic [15:0]          usbData;
  logic                 usbEmpty;
  logic                 testDone;

  rowT         stimTable [NUM_ROWS];
  rowT         curRow;
  logic [15:0] expWords [$];
  logic [15:0] gotWords [$];  // Everything the host pulled over all rows
  logic [5:0]  expChn [$];    // Channel and DAC of each scan point
  logic [9:0]  expDac [$];
  int          errors;
  int          checks;
  int          monErrors;
  int          monChecks;
  int          cycle;
  int          cycleLimit;
  int          rowStart;
  int          burstCount;
  int          srEnCycles;
  int          rowBurstBase;
  int          rowSrEnBase;

  scurveTestTop dut_i (.*);

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  //////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////

  function automatic int unsigned lcgNext(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [9:0] flipBits(input logic [9:0] code);
    logic [9:0] flipped;
    flipped = {<<{code}};
    return flipped;
  endfunction

  function automatic scurvePkg::scConfigT expectedConfig(input scurvePkg::scanParamT p,
                                                         input logic [5:0] chn,
                                                         input logic [9:0] dac);
    scurvePkg::scConfigT cfg;
    cfg = '0;
    if (p.ctestInject) cfg.ctestChn[chn] = 1'b1;
    for (int i = 0; i < 192; i++) begin
      cfg.discriMask[i] = p.unmaskAll || (i / 3 == int'(chn));  // Three bits per channel
    end
    cfg.dacCode     = flipBits(dac);
    cfg.forceExtRaz = 1'b1;  // Held high through load and settle
    return cfg;
  endfunction

  task automatic buildExpected(input rowT row);
    logic [5:0] chn;
    logic [9:0] dac;
    int         nChn;
    expWords.delete();
    expChn.delete();
    expDac.delete();
    expWords.push_back(scurvePkg::SCURVE_HEADER);
    nChn = row.param.singleChn ? 1 : 64;
    for (int c = 0; c < nChn; c++) begin
      chn = row.param.singleChn ? row.param.testChn : 6'(c);
      if (row.param.unmaskAll) begin
        expWords.push_back(scurvePkg::CHN_WORD_UNMASKED);
      end else begin
        expWords.push_back({row.param.singleChn ? scurvePkg::CHN_TAG_SINGLE
                                                : scurvePkg::CHN_TAG_ALL, 2'b00, chn});
      end
      dac = row.param.startDac;
      for (int guard = 0; guard < 1024; guard++) begin
        expWords.push_back({scurvePkg::DAC_TAG, 2'b00, dac});
        expWords.push_back({11'(dac) < row.threshold} ? 16'(scurvePkg::TRIG_WINDOW) : 16'd0);
        expChn.push_back(chn);
        expDac.push_back(dac);
        if (dac == row.param.endDac) break;
        dac = dac + row.param.dacStep;
      end
    end
    expWords.push_back(scurvePkg::SCURVE_TAIL);
  endtask

  task automatic checkTrue(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0d ns: %s", $time, what);
    end
  endtask

  task automatic expectWord(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expectCount(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic loadTable();
    // Single channel, test pin, four points across the threshold
    stimTable[0] = '{param: '{singleChn: 1'b1, testChn: 6'd5, ctestInject: 1'b1,
                              startDac: 10'd10, endDac: 10'd40, dacStep: 10'd10,
                              asicNumber: 3'd1, unmaskAll: 1'b0},
                     threshold: 11'd25, stall: 1'b0};
    stimTable[1] = '{param: '{singleChn: 1'b1, testChn: 6'd42, ctestInject: 1'b0,
                              startDac: 10'd300, endDac: 10'd303, dacStep: 10'd1,
                              asicNumber: 3'd2, unmaskAll: 1'b1},
                     threshold: 11'd302, stall: 1'b0};
    stimTable[2] = '{param: '{singleChn: 1'b0, testChn: 6'd0, ctestInject: 1'b1,
                              startDac: 10'd7, endDac: 10'd7, dacStep: 10'd1,
                              asicNumber: 3'd1, unmaskAll: 1'b0},
                     threshold: 11'd8, stall: 1'b0};
    // No loads, so words pile up fast while the host is quiet
    stimTable[3] = '{param: '{singleChn: 1'b1, testChn: 6'd63, ctestInject: 1'b1,
                              startDac: 10'd0, endDac: 10'd600, dacStep: 10'd20,
                              asicNumber: 3'd0, unmaskAll: 1'b0},
                     threshold: 11'd333, stall: 1'b1};
  endtask

  task automatic runRow(input rowT row);
    int base;
    buildExpected(row);
    base         = gotWords.size();
    curRow       = row;
    rowBurstBase = burstCount;
    rowSrEnBase  = srEnCycles;
    rowStart     = cycle;
    scanParam    = row.param;
    testStart    = 1'b1;
    if (row.stall) begin
      repeat (STALL_CYCLES - 10) @(negedge Clk);
      checkTrue(dut_i.usbFull, "USB FIFO not full during host stall");
    end
    while (!testDone) @(negedge Clk);
    testStart = 1'b0;
    repeat (4) begin
      @(negedge Clk);
      checkTrue(testDone, "testDone dropped before transmitDone");
    end
    transmitDone = 1'b1;
    @(negedge Clk);
    transmitDone = 1'b0;
    checkTrue(!testDone, "testDone still high after transmitDone");
    while (gotWords.size() - base < expWords.size()) @(negedge Clk);
    repeat (20) @(negedge Clk);  // Room for any extra word to show up
    expectCount(gotWords.size() - base, expWords.size(), "stream length");
    for (int i = 0; i < expWords.size(); i++) begin
      expectWord(gotWords[base + i], expWords[i], $sformatf("stream word %0d", i));
    end
    expectCount(burstCount - rowBurstBase, expDac.size() * int'(row.param.asicNumber),
                "slow-control loads");
    expectCount(srEnCycles - rowSrEnBase,
                expDac.size() * int'(row.param.asicNumber) * scurvePkg::SC_BITS, "srEn cycles");
  endtask

  //////////////////////////////////////////////////
  // Host reads, ASIC model, timeout
  //////////////////////////////////////////////////

  initial begin
    int unsigned rnd;
    rnd   = LCG_SEED;
    usbRd = 1'b0;
    forever begin
      @(negedge Clk);
      rnd = lcgNext(rnd);
      if (!usbEmpty && !(curRow.stall && cycle - rowStart < STALL_CYCLES) && rnd[16]) begin
        usbRd = 1'b1;
        gotWords.push_back(usbData);  // Fall-through word
      end else begin
        usbRd = 1'b0;
      end
    end
  end

  initial begin
    scurvePkg::scConfigT lastConfig;
    scurvePkg::scConfigT image;
    logic                lastSrEn;
    int                  bitIdx;
    int                  pointIdx;
    trigger    = 1'b0;
    burstCount = 0;
    srEnCycles = 0;
    monErrors  = 0;
    monChecks  = 0;
    lastSrEn   = 1'b0;
    lastConfig = '0;
    image      = '0;
    bitIdx     = 0;
    forever begin
      @(negedge Clk);
      trigger = {1'b0, flipBits(scConfig.dacCode)} < curRow.threshold;
      if (srEn) begin
        if (!lastSrEn && curRow.param.asicNumber != 3'd0) begin
          image    = lastConfig;  // What the loader latched on scLoad
          bitIdx   = 0;
          pointIdx = (burstCount - rowBurstBase) / int'(curRow.param.asicNumber);
          if (pointIdx < expDac.size()) begin
            monChecks++;
            assert (image == expectedConfig(curRow.param, expChn[pointIdx], expDac[pointIdx]))
            else begin
              monErrors++;
              $display("Error at %0d ns: slow-control image wrong at point %0d",
                       $time, pointIdx);
            end
          end
        end
        monChecks++;
        assert (bitIdx < scurvePkg::SC_BITS && srData == image[scurvePkg::SC_BITS - 1 - bitIdx])
        else begin
          monErrors++;
          $display("Error at %0d ns: serial bit %0d wrong", $time, bitIdx);
        end
        bitIdx++;
        srEnCycles++;
      end else if (lastSrEn) begin
        monChecks++;
        assert (bitIdx == scurvePkg::SC_BITS) else begin
          monErrors++;
          $display("Error at %0d ns: load burst of %0d bits", $time, bitIdx);
        end
        burstCount++;
      end
      lastSrEn   = srEn;
      lastConfig = scConfig;
    end
  end

  initial begin
    cycle = 0;
    while (cycleLimit == 0 || cycle <= cycleLimit) begin
      @(posedge Clk);
      cycle++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Checks: %0d, errors: %0d", checks + monChecks, errors + monErrors);
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int limit;
    reset_n      = 1'b0;
    testStart    = 1'b0;
    scanParam    = '0;
    transmitDone = 1'b0;
    curRow       = '0;
    rowStart     = 0;
    rowBurstBase = 0;
    rowSrEnBase  = 0;
    errors       = 0;
    checks       = 0;
    loadTable();
    limit = 2000;
    for (int r = 0; r < NUM_ROWS; r++) begin
      buildExpected(stimTable[r]);
      limit += expDac.size() * (int'(stimTable[r].param.asicNumber)
               * (scurvePkg::SC_BITS + 70) + 60) + 100;
      if (stimTable[r].stall) limit += STALL_CYCLES;
    end
    cycleLimit = limit;
    repeat (5) @(negedge Clk);
    reset_n = 1'b1;
    @(negedge Clk);
    checkTrue(!testDone, "testDone high after reset");
    checkTrue(usbEmpty && !srEn, "USB FIFO or loader busy after reset");
    checkTrue(scConfig.discriMask === '1 && scConfig.dacCode == '0 && scConfig.ctestChn == '0
              && !scConfig.forceExtRaz, "scConfig not at its reset image");
    for (int r = 0; r < NUM_ROWS; r++) begin
      runRow(stimTable[r]);
    end
    $display("Checks: %0d, errors: %0d", checks + monChecks, errors + monErrors);
    if (errors + monErrors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
common/scurvePkg.sv
rtl/syncFifo.sv
rtl/triggerCounter.sv
rtl/scParamLoader.sv
scanControl/scurveScanControl.sv
rtl/scurveTestTop.sv
verification/scurveTestTb.sv

// ==== Makefile ====
TOP = scurveTestTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
